//--- hdl/bank_mem_pkg.sv
package bank_mem_pkg;

  parameter int DATA_W       = 32;
  parameter int BE_W         = DATA_W / 8;
  parameter int ADDR_W       = 32;

  // Bit 2 interleaves consecutive words over the two banks
  parameter int BANK_SEL_BIT = 2;
  parameter int WORD_LSB     = 3;

  // Request as driven by a requester on one lane
  typedef struct packed {
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } lane_req_t;

  typedef struct packed {
    logic              ack;
    logic              resp;
    logic [DATA_W-1:0] rdata;
  } lane_rsp_t;

  // Request after routing as seen by one bank slot
  typedef struct packed {
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } slot_req_t;

  typedef struct packed {
    logic                       we;
    logic [ADDR_W-WORD_LSB-1:0] addr;
    logic [DATA_W-1:0]          wdata;
  } bank_cmd_t;

  typedef enum logic {
    MRG_IDLE,
    MRG_WRITE
  } merge_state_e;

endpackage

//--- hdl/bank_ram.sv
`timescale 1ns/1ps

module bank_ram
#(
  parameter int BANK_WORDS = 256
)
(
  input  logic                            clk_i,

  input  bank_mem_pkg::bank_cmd_t         port_a_cmd_i,
  output logic [bank_mem_pkg::DATA_W-1:0] port_a_rdata_o,

  input  bank_mem_pkg::bank_cmd_t         port_b_cmd_i,
  output logic [bank_mem_pkg::DATA_W-1:0] port_b_rdata_o
);

  localparam int IDX_W = $clog2(BANK_WORDS);

  logic [bank_mem_pkg::DATA_W-1:0] mem [BANK_WORDS];
  logic [IDX_W-1:0]                idx_a;
  logic [IDX_W-1:0]                idx_b;

  // Low word address bits select the entry
  assign idx_a = port_a_cmd_i.addr[IDX_W-1:0];
  assign idx_b = port_b_cmd_i.addr[IDX_W-1:0];

  // Read returns the word as it was before this edge
  always_ff @(posedge clk_i)
  begin
    if (port_a_cmd_i.we)
    begin
      mem[idx_a] <= port_a_cmd_i.wdata;
    end
    if (port_b_cmd_i.we)
    begin
      mem[idx_b] <= port_b_cmd_i.wdata;
    end
    port_a_rdata_o <= mem[idx_a];
    port_b_rdata_o <= mem[idx_b];
  end

endmodule

//--- hdl/merge_fsm.sv
`timescale 1ns/1ps

module merge_fsm
(
  input  logic                              clk_i,
  input  logic                              rst_n_i,

  input  bank_mem_pkg::slot_req_t           slot_req_i,
  input  logic [bank_mem_pkg::DATA_W-1:0]   bank_rdata_i,
  output logic                              busy_o,
  output bank_mem_pkg::bank_cmd_t           bank_cmd_o
);

  bank_mem_pkg::merge_state_e state_q;
  bank_mem_pkg::merge_state_e state_d;

  logic                                                   partial_wr;
  logic [bank_mem_pkg::ADDR_W-bank_mem_pkg::WORD_LSB-1:0] addr_q;
  logic [bank_mem_pkg::BE_W-1:0]                          be_q;
  logic [bank_mem_pkg::DATA_W-1:0]                        wdata_q;
  logic [bank_mem_pkg::DATA_W-1:0]                        merged;

  // Only taken requests reach this point with req high
  assign partial_wr = slot_req_i.req && slot_req_i.we && !(&slot_req_i.be);

  assign busy_o = (state_q == bank_mem_pkg::MRG_WRITE);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      bank_mem_pkg::MRG_IDLE:
      begin
        if (partial_wr)
        begin
          state_d = bank_mem_pkg::MRG_WRITE;
        end
      end
      bank_mem_pkg::MRG_WRITE:
      begin
        state_d = bank_mem_pkg::MRG_IDLE;
      end
      default:
      begin
        state_d = bank_mem_pkg::MRG_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= bank_mem_pkg::MRG_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Old word arrives from the RAM while in MRG_WRITE
  always_ff @(posedge clk_i)
  begin
    if ((state_q == bank_mem_pkg::MRG_IDLE) && partial_wr)
    begin
      addr_q  <= slot_req_i.addr[bank_mem_pkg::ADDR_W-1:bank_mem_pkg::WORD_LSB];
      be_q    <= slot_req_i.be;
      wdata_q <= slot_req_i.wdata;
    end
  end

  always_comb
  begin
    merged = bank_rdata_i;
    for (int i = 0; i < bank_mem_pkg::BE_W; i++)
    begin
      if (be_q[i])
      begin
        merged[8*i +: 8] = wdata_q[8*i +: 8];
      end
    end
  end

  always_comb
  begin
    if (state_q == bank_mem_pkg::MRG_WRITE)
    begin
      bank_cmd_o.we    = 1'b1;
      bank_cmd_o.addr  = addr_q;
      bank_cmd_o.wdata = merged;
    end
    else
    begin
      // Partial write turns into a plain read of the old word
      bank_cmd_o.we    = slot_req_i.req && slot_req_i.we && !partial_wr;
      bank_cmd_o.addr  = slot_req_i.addr[bank_mem_pkg::ADDR_W-1:bank_mem_pkg::WORD_LSB];
      bank_cmd_o.wdata = slot_req_i.wdata;
    end
  end

endmodule

//--- hdl/lane_router.sv
`timescale 1ns/1ps

module lane_router
(
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  input  bank_mem_pkg::lane_req_t [1:0]        lane_req_i,
  input  logic [1:0]                           slot_busy_i,
  output bank_mem_pkg::slot_req_t [1:0]        slot_req_o,

  input  logic [1:0][bank_mem_pkg::DATA_W-1:0] slot_rdata_i,
  output bank_mem_pkg::lane_rsp_t [1:0]        lane_rsp_o
);

  // want[slot][lane]
  logic [1:0][1:0] want;
  logic [1:0]      slot_win;
  logic [1:0]      slot_take;

  // Pending read per slot and the lane that owns it
  logic [1:0]      rd_pend_q;
  logic [1:0]      rd_lane_q;

  always_comb
  begin
    for (int b = 0; b < 2; b++)
    begin
      for (int l = 0; l < 2; l++)
      begin
        want[b][l] = lane_req_i[l].req &&
                     (lane_req_i[l].addr[bank_mem_pkg::BANK_SEL_BIT] == 1'(b));
      end
    end
  end

  always_comb
  begin
    for (int b = 0; b < 2; b++)
    begin
      // Lane 0 wins a same-bank conflict
      slot_win[b]  = !want[b][0];
      slot_take[b] = (want[b][0] || want[b][1]) && !slot_busy_i[b];

      slot_req_o[b].req   = slot_take[b];
      slot_req_o[b].we    = lane_req_i[slot_win[b]].we;
      slot_req_o[b].addr  = lane_req_i[slot_win[b]].addr;
      slot_req_o[b].be    = lane_req_i[slot_win[b]].be;
      slot_req_o[b].wdata = lane_req_i[slot_win[b]].wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rd_pend_q <= '0;
      rd_lane_q <= '0;
    end
    else
    begin
      for (int b = 0; b < 2; b++)
      begin
        rd_pend_q[b] <= slot_take[b] && !lane_req_i[slot_win[b]].we;
        rd_lane_q[b] <= slot_win[b];
      end
    end
  end

  always_comb
  begin
    for (int l = 0; l < 2; l++)
    begin
      lane_rsp_o[l].ack   = 1'b0;
      lane_rsp_o[l].resp  = 1'b0;
      lane_rsp_o[l].rdata = '0;
      for (int b = 0; b < 2; b++)
      begin
        if (want[b][l] && slot_take[b] && (slot_win[b] == 1'(l)))
        begin
          lane_rsp_o[l].ack = 1'b1;
        end
        // A lane owns at most one slot's read per cycle
        if (rd_pend_q[b] && (rd_lane_q[b] == 1'(l)))
        begin
          lane_rsp_o[l].resp  = 1'b1;
          lane_rsp_o[l].rdata = slot_rdata_i[b];
        end
      end
    end
  end

endmodule

//--- hdl/bus_port.sv
`timescale 1ns/1ps

module bus_port
(
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  // Requester side with one entry per lane
  input  bank_mem_pkg::lane_req_t [1:0]        lane_req_i,
  output bank_mem_pkg::lane_rsp_t [1:0]        lane_rsp_o,

  // RAM side with one entry per bank
  output bank_mem_pkg::bank_cmd_t [1:0]        bank_cmd_o,
  input  logic [1:0][bank_mem_pkg::DATA_W-1:0] bank_rdata_i
);

  bank_mem_pkg::slot_req_t [1:0] slot_req;
  logic [1:0]                    slot_busy;

  // Lane to bank steering and the read response timing
  lane_router u_router
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .lane_req_i   (lane_req_i),
    .slot_busy_i  (slot_busy),
    .slot_req_o   (slot_req),
    .slot_rdata_i (bank_rdata_i),
    .lane_rsp_o   (lane_rsp_o)
  );

  // One merge controller in front of each bank port
  for (genvar b = 0; b < 2; b++)
  begin : g_slot
    merge_fsm u_merge
    (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .slot_req_i   (slot_req[b]),
      .bank_rdata_i (bank_rdata_i[b]),
      .busy_o       (slot_busy[b]),
      .bank_cmd_o   (bank_cmd_o[b])
    );
  end

endmodule

//--- hdl/bank_mem_top.sv
`timescale 1ns/1ps

module bank_mem_top
#(
  parameter int BANK_WORDS = 256
)
(
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  input  bank_mem_pkg::lane_req_t [1:0] bus0_lane_req_i,
  output bank_mem_pkg::lane_rsp_t [1:0] bus0_lane_rsp_o,

  input  bank_mem_pkg::lane_req_t [1:0] bus1_lane_req_i,
  output bank_mem_pkg::lane_rsp_t [1:0] bus1_lane_rsp_o
);

  // Indexed by bank with bus 0 on port A and bus 1 on port B
  bank_mem_pkg::bank_cmd_t [1:0]        bus0_cmd;
  bank_mem_pkg::bank_cmd_t [1:0]        bus1_cmd;
  logic [1:0][bank_mem_pkg::DATA_W-1:0] bus0_rdata;
  logic [1:0][bank_mem_pkg::DATA_W-1:0] bus1_rdata;

  bus_port u_bus0
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .lane_req_i   (bus0_lane_req_i),
    .lane_rsp_o   (bus0_lane_rsp_o),
    .bank_cmd_o   (bus0_cmd),
    .bank_rdata_i (bus0_rdata)
  );

  bus_port u_bus1
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .lane_req_i   (bus1_lane_req_i),
    .lane_rsp_o   (bus1_lane_rsp_o),
    .bank_cmd_o   (bus1_cmd),
    .bank_rdata_i (bus1_rdata)
  );

  bank_ram
  #(
    .BANK_WORDS (BANK_WORDS)
  )
  u_bank0
  (
    .clk_i          (clk_i),
    .port_a_cmd_i   (bus0_cmd[0]),
    .port_a_rdata_o (bus0_rdata[0]),
    .port_b_cmd_i   (bus1_cmd[0]),
    .port_b_rdata_o (bus1_rdata[0])
  );

  bank_ram
  #(
    .BANK_WORDS (BANK_WORDS)
  )
  u_bank1
  (
    .clk_i          (clk_i),
    .port_a_cmd_i   (bus0_cmd[1]),
    .port_a_rdata_o (bus0_rdata[1]),
    .port_b_cmd_i   (bus1_cmd[1]),
    .port_b_rdata_o (bus1_rdata[1])
  );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held low over the first two rising edges
  initial
  begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

//--- sim/bank_mem_properties.sv
`timescale 1ns/1ps

module bank_mem_properties
(
  input logic                       clk_i,
  input logic                       rst_n_i,
  input bank_mem_pkg::merge_state_e state_i,
  input logic                       busy_i,
  input bank_mem_pkg::slot_req_t    slot_req_i
);

  logic partial_acc;

  assign partial_acc = slot_req_i.req && slot_req_i.we && !(&slot_req_i.be) &&
                       (state_i == bank_mem_pkg::MRG_IDLE);

  a_write_one_cycle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_i == bank_mem_pkg::MRG_WRITE) |=> (state_i == bank_mem_pkg::MRG_IDLE))
  else
    $error("merge write state lasted longer than one cycle");

  // Busy only in the merge cycle right after a taken partial write
  a_busy_in_write : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_i |-> $past(partial_acc))
  else
    $error("busy raised without a partial write taken in the cycle before");

  // Partial write taken in idle must start a merge
  a_partial_to_write : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    partial_acc |=> (state_i == bank_mem_pkg::MRG_WRITE))
  else
    $error("partial write did not lead to the merge write state");

endmodule

bind merge_fsm bank_mem_properties u_props
(
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .state_i    (state_q),
  .busy_i     (busy_o),
  .slot_req_i (slot_req_i)
);

//--- sim/tb_bank_mem.sv
`timescale 1ns/1ps

module tb_bank_mem;

  typedef struct packed {
    logic [1:0]  lane;
    logic [31:0] data;
  } exp_t;

  // Cycle budgets of all tests summed
  localparam int BUDGET = 10 + 270 + 120 + 320 + 80 + 60 + 90;

  logic                          clk;
  logic                          rst_n;
  bank_mem_pkg::lane_req_t [1:0] bus0_req;
  bank_mem_pkg::lane_rsp_t [1:0] bus0_rsp;
  bank_mem_pkg::lane_req_t [1:0] bus1_req;
  bank_mem_pkg::lane_rsp_t [1:0] bus1_rsp;

  // Lane number is {bus, lane}
  bank_mem_pkg::lane_req_t req_v [4];
  logic [3:0]              ack_v;
  logic [31:0]             model [512];
  exp_t                    exp_q [$];
  int                      seed = 89;
  int                      err_count = 0;
  int                      check_count = 0;
  int                      test_count = 0;

  tb_clock_gen u_clk
  (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  bank_mem_top
  #(
    .BANK_WORDS (256)
  )
  u_dut
  (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .bus0_lane_req_i (bus0_req),
    .bus0_lane_rsp_o (bus0_rsp),
    .bus1_lane_req_i (bus1_req),
    .bus1_lane_rsp_o (bus1_rsp)
  );

  function automatic logic [31:0] addr_of(input logic [8:0] w);
    return {21'd0, w, 2'b00};
  endfunction

  function automatic logic [31:0] fill_word(input logic [8:0] w);
    return {w, 7'h35, ~w, 7'h4b};
  endfunction

  // Expected word after a write with byte enables
  function automatic logic [31:0] merge_word(input logic [31:0] old_w, input logic [3:0] be,
                                             input logic [31:0] wdata);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (wdata & mask) | (old_w & ~mask);
  endfunction

  function automatic bank_mem_pkg::lane_rsp_t rsp_of(input logic [1:0] l);
    if (l[1])
    begin
      return bus1_rsp[l[0]];
    end
    return bus0_rsp[l[0]];
  endfunction

  task automatic check_ack(input logic [1:0] l, input logic exp_ack);
    check_count++;
    assert (ack_v[l] == exp_ack)
    else
    begin
      $display("CHECK FAILED bus%0d_lane_rsp_o[%0d].ack: got 0x%h, expected 0x%h",
               l[1], l[0], ack_v[l], exp_ack);
      err_count++;
    end
  endtask

  task automatic set_req(input logic [1:0] l, input logic we, input logic [8:0] w,
                         input logic [3:0] be, input logic [31:0] d);
    req_v[l].req   = 1'b1;
    req_v[l].we    = we;
    req_v[l].addr  = addr_of(w);
    req_v[l].be    = be;
    req_v[l].wdata = d;
  endtask

  task automatic clear_all();
    req_v[0].req = 1'b0;
    req_v[1].req = 1'b0;
    req_v[2].req = 1'b0;
    req_v[3].req = 1'b0;
  endtask

  // Drive one cycle, sample the acks and update the model
  task automatic step();
    logic [1:0] l;
    exp_t       e;
    @(posedge clk);
    #1;
    bus0_req[0] = req_v[0];
    bus0_req[1] = req_v[1];
    bus1_req[0] = req_v[2];
    bus1_req[1] = req_v[3];
    #2;
    ack_v = {bus1_rsp[1].ack, bus1_rsp[0].ack, bus0_rsp[1].ack, bus0_rsp[0].ack};
    // Reads see memory before this cycle's writes
    for (int i = 0; i < 4; i++)
    begin
      l = 2'(i);
      if (!req_v[l].req)
      begin
        check_ack(l, 1'b0);
      end
      else if (ack_v[l] && !req_v[l].we)
      begin
        e.lane = l;
        e.data = model[req_v[l].addr[10:2]];
        exp_q.push_back(e);
      end
    end
    for (int i = 0; i < 4; i++)
    begin
      l = 2'(i);
      if (req_v[l].req && ack_v[l] && req_v[l].we)
      begin
        model[req_v[l].addr[10:2]] = merge_word(model[req_v[l].addr[10:2]], req_v[l].be,
                                                req_v[l].wdata);
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  // Hold a request until it is taken
  task automatic issue(input logic [1:0] l, input logic we, input logic [8:0] w,
                       input logic [3:0] be, input logic [31:0] d);
    set_req(l, we, w, be, d);
    step();
    while (!ack_v[l])
    begin
      step();
    end
    req_v[l].req = 1'b0;
  endtask

  task automatic report(input string name, input int start_err);
    test_count++;
    $display("Test %s done with %0d errors", name, err_count - start_err);
  endtask

  initial
  begin : compare_rsp
    exp_t                    e;
    logic [3:0]              exp_valid;
    logic [31:0]             exp_data [4];
    logic [1:0]              l;
    bank_mem_pkg::lane_rsp_t r;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge clk);
      exp_valid = '0;
      while (exp_q.size() > 0)
      begin
        e = exp_q.pop_front();
        exp_valid[e.lane] = 1'b1;
        exp_data[e.lane] = e.data;
      end
      for (int i = 0; i < 4; i++)
      begin
        l = 2'(i);
        r = rsp_of(l);
        check_count++;
        assert (r.resp == exp_valid[l])
        else
        begin
          $display("CHECK FAILED bus%0d_lane_rsp_o[%0d].resp: got 0x%h, expected 0x%h",
                   l[1], l[0], r.resp, exp_valid[l]);
          err_count++;
        end
        if (r.resp && exp_valid[l])
        begin
          check_count++;
          assert (r.rdata == exp_data[l])
          else
          begin
            $display("CHECK FAILED bus%0d_lane_rsp_o[%0d].rdata: got 0x%h, expected 0x%h",
                     l[1], l[0], r.rdata, exp_data[l]);
            err_count++;
          end
        end
      end
    end
  end

  initial
  begin : watchdog
    #(BUDGET * 4 + 400);
    $display("Watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin : stimulus
    logic [31:0] rnd;
    logic [8:0]  w;
    logic [1:0]  la;
    logic [1:0]  lb;
    logic [1:0]  lc;
    logic        k;
    int          start_err;
    bus0_req = '0;
    bus1_req = '0;
    ack_v    = '0;
    for (int i = 0; i < 4; i++)
    begin
      req_v[2'(i)] = '0;
    end
    wait (rst_n === 1'b1);

    start_err = err_count;
    idle(8);
    report("reset_idle", start_err);

    // Both lanes of bus 0 write in parallel with one lane per bank
    start_err = err_count;
    for (int i = 0; i < 256; i++)
    begin
      w = 9'(2 * i);
      set_req(2'd0, 1'b1, w, 4'hf, fill_word(w));
      set_req(2'd1, 1'b1, w + 9'd1, 4'hf, fill_word(w + 9'd1));
      step();
      check_ack(2'd0, 1'b1);
      check_ack(2'd1, 1'b1);
    end
    clear_all();
    idle(2);
    report("fill_writes", start_err);

    start_err = err_count;
    for (int i = 0; i < 40; i++)
    begin
      rnd = $random(seed);
      w   = rnd[8:0];
      la  = rnd[10:9];
      lb  = la + ((rnd[12:11] == 2'd0) ? 2'd1 : rnd[12:11]);
      issue(la, 1'b1, w, 4'hf, $random(seed));
      issue(lb, 1'b0, w, 4'hf, '0);
    end
    idle(2);
    report("full_round_trip", start_err);

    start_err = err_count;
    for (int i = 0; i < 40; i++)
    begin
      rnd = $random(seed);
      w   = rnd[8:0];
      la  = rnd[10:9];
      lb  = rnd[12:11];
      issue(la, 1'b1, w, rnd[16:13], $random(seed));
      // Let the merge write land before reading back
      idle(1);
      issue(lb, 1'b0, w, 4'hf, '0);
    end
    idle(2);
    report("partial_merge", start_err);

    start_err = err_count;
    for (int i = 0; i < 32; i++)
    begin
      rnd = $random(seed);
      la  = {i[4], 1'b0};
      lb  = {i[4], 1'b1};
      k   = i[0];
      clear_all();
      set_req(la, 1'b0, {rnd[7:0], k}, 4'hf, '0);
      set_req(lb, 1'b0, {rnd[15:8], !k}, 4'hf, '0);
      step();
      check_ack(la, 1'b1);
      check_ack(lb, 1'b1);
    end
    clear_all();
    idle(2);
    report("parallel_lanes", start_err);

    start_err = err_count;
    for (int i = 0; i < 16; i++)
    begin
      rnd = $random(seed);
      la  = {i[3], 1'b0};
      lb  = {i[3], 1'b1};
      w   = {rnd[7:0], rnd[16]};
      set_req(la, 1'b0, w, 4'hf, '0);
      set_req(lb, 1'b0, w ^ 9'h2, 4'hf, '0);
      step();
      check_ack(la, 1'b1);
      check_ack(lb, 1'b0);
      req_v[la].req = 1'b0;
      step();
      check_ack(lb, 1'b1);
      clear_all();
    end
    idle(2);
    report("same_bank_conflict", start_err);

    start_err = err_count;
    for (int i = 0; i < 16; i++)
    begin
      rnd = $random(seed);
      la  = {i[3], 1'b0};
      lb  = {i[3], 1'b1};
      lc  = {!i[3], 1'b0};
      k   = rnd[9];
      w   = {rnd[7:0], k};
      set_req(la, 1'b1, w, (&rnd[13:10]) ? 4'h7 : rnd[13:10], $random(seed));
      step();
      check_ack(la, 1'b1);
      // In the merge cycle only the busy slot refuses
      set_req(la, 1'b0, {rnd[17:10], !k}, 4'hf, '0);
      set_req(lb, 1'b0, w ^ 9'h2, 4'hf, '0);
      set_req(lc, 1'b0, w ^ 9'h4, 4'hf, '0);
      step();
      check_ack(la, 1'b1);
      check_ack(lb, 1'b0);
      check_ack(lc, 1'b1);
      req_v[la].req = 1'b0;
      req_v[lc].req = 1'b0;
      step();
      check_ack(lb, 1'b1);
      clear_all();
    end
    idle(2);
    report("merge_backpressure", start_err);

    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
hdl/bank_mem_pkg.sv
hdl/bank_ram.sv
hdl/merge_fsm.sv
hdl/lane_router.sv
hdl/bus_port.sv
hdl/bank_mem_top.sv
sim/tb_clock_gen.sv
sim/bank_mem_properties.sv
sim/tb_bank_mem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bank memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_bank_mem -f vlog.f -o tb_bank_mem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_bank_mem > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

grep -q "RESULT: FAIL" "$LOG"
grep_status=$?
if [ $grep_status -eq 0 ]; then
  exit 1
elif [ $grep_status -ne 1 ]; then
  echo "Could not search $LOG"
  exit 1
fi
exit 0
